/* cpu.f */
logic/cpu_isa_pkg.sv
logic/cpu_ctrl_pkg.sv
logic/control_fsm.sv
logic/program_counter.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/execute_unit.sv
logic/cpu.sv
tests/cpu_checker.sv
tests/cpu_tb.sv

/* logic/control_fsm.sv */
// instruction sequencer: fetch, dispatch and per-step control of the datapath and memory port
`timescale 1ns/1ps

module control_fsm import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  opcode_t    opcode,
	input  op_t        op,
	input  cond_t      cond,
	input  logic [2:0] flags,
	output dp_ctrl_t   dp_ctrl,
	output addr_ctrl_t addr_ctrl,
	output logic       load_ir,
	output mem_cmd_t   mem_cmd,
	output logic       halt
);

	localparam dp_ctrl_t dp_idle = '{reg_sel: sel_rn, wb_sel: wb_c, default: 1'b0};

	state_t state;
	state_t next_state;
	logic   cond_true;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_reset;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (cond)
			cond_al: cond_true = 1'b1;
			cond_eq: cond_true = flags[flag_z];
			cond_ne: cond_true = ~flags[flag_z];
			cond_lt: cond_true = flags[flag_n] ^ flags[flag_v];
			cond_le: cond_true = (flags[flag_n] ^ flags[flag_v]) | flags[flag_z];
			default: cond_true = 1'b0;	// unused codes never branch
		endcase
	end

	always_comb begin
		next_state = state;
		dp_ctrl = dp_idle;
		addr_ctrl = '0;
		load_ir = 1'b0;
		mem_cmd = cmd_none;
		case (state)
			s_reset: begin
				addr_ctrl.reset_pc = 1'b1;
				addr_ctrl.load_pc = 1'b1;
				next_state = s_if1;
			end
			s_if1: begin
				addr_ctrl.addr_pc = 1'b1;
				mem_cmd = cmd_read;
				next_state = s_if2;
			end
			s_if2: begin
				addr_ctrl.addr_pc = 1'b1;
				mem_cmd = cmd_read;
				load_ir = 1'b1;
				next_state = s_update_pc;
			end
			s_update_pc: begin
				addr_ctrl.load_pc = 1'b1;	// pc + 1
				case ({opcode, op})
					instr_mov_imm: next_state = s_mov_imm;
					instr_mov_reg, instr_mvn: next_state = s_load_b;
					instr_add, instr_and, instr_cmp: next_state = s_load_a;
					instr_ldr, instr_str: next_state = s_load_a;
					instr_branch: next_state = s_branch;
					instr_halt: next_state = s_halt;
					default: next_state = s_if1;	// unknown encoding is a no-op
				endcase
			end
			s_mov_imm: begin
				dp_ctrl.reg_sel = sel_rn;
				dp_ctrl.wb_sel = wb_imm8;
				dp_ctrl.write = 1'b1;
				next_state = s_if1;
			end
			s_load_a: begin
				dp_ctrl.reg_sel = sel_rn;
				dp_ctrl.load_a = 1'b1;
				if (opcode == opc_ldr || opcode == opc_str) begin
					next_state = s_addr_calc;
				end else begin
					next_state = s_load_b;
				end
			end
			s_load_b: begin
				dp_ctrl.reg_sel = sel_rm;
				dp_ctrl.load_b = 1'b1;
				next_state = ({opcode, op} == instr_cmp) ? s_status : s_calc;
			end
			s_calc: begin
				dp_ctrl.load_c = 1'b1;
				dp_ctrl.a_zero = (opcode == opc_mov);	// mov rd, rm is 0 + shifted rm
				next_state = s_write;
			end
			s_write: begin
				dp_ctrl.reg_sel = sel_rd;
				dp_ctrl.wb_sel = wb_c;
				dp_ctrl.write = 1'b1;
				next_state = s_if1;
			end
			s_status: begin
				dp_ctrl.load_s = 1'b1;
				next_state = s_if1;
			end
			s_addr_calc: begin
				dp_ctrl.b_imm = 1'b1;	// rn + sximm5
				dp_ctrl.load_c = 1'b1;
				next_state = s_load_addr;
			end
			s_load_addr: begin
				addr_ctrl.load_addr = 1'b1;
				dp_ctrl.reg_sel = sel_rd;	// store data, ignored by ldr
				dp_ctrl.load_b = 1'b1;
				next_state = (opcode == opc_str) ? s_str_data : s_mem_read;
			end
			s_mem_read: begin
				mem_cmd = cmd_read;
				next_state = s_mem_wb;
			end
			s_mem_wb: begin
				mem_cmd = cmd_read;
				dp_ctrl.reg_sel = sel_rd;
				dp_ctrl.wb_sel = wb_mem;
				dp_ctrl.write = 1'b1;
				next_state = s_if1;
			end
			s_str_data: begin
				dp_ctrl.a_zero = 1'b1;	// c = rd
				dp_ctrl.load_c = 1'b1;
				next_state = s_mem_write1;
			end
			s_mem_write1: begin
				mem_cmd = cmd_write;
				next_state = s_mem_write2;
			end
			s_mem_write2: begin
				mem_cmd = cmd_write;
				next_state = s_if1;
			end
			s_branch: begin
				addr_ctrl.take_branch = cond_true;
				addr_ctrl.load_pc = cond_true;
				next_state = s_if1;
			end
			s_halt: begin
				addr_ctrl.reset_pc = 1'b1;	// park pc at 0 until reset
				addr_ctrl.load_pc = 1'b1;
			end
			default: next_state = s_reset;
		endcase
	end

	assign halt = (state == s_halt);

endmodule

/* logic/cpu.sv */
// processor top level: sequencer, program counter, decoder, register file and execute unit
`timescale 1ns/1ps

module cpu import cpu_isa_pkg::*, cpu_ctrl_pkg::*; #(
	parameter int addr_width = 9
) (
	input  logic                  clk,
	input  logic                  reset,
	input  word_t                 read_data,
	output mem_cmd_t              mem_cmd,
	output logic [addr_width-1:0] mem_addr,
	output word_t                 datapath_out,
	output logic                  halt
);

	dp_ctrl_t   dp_ctrl;
	addr_ctrl_t addr_ctrl;
	logic       load_ir;
	opcode_t    opcode;
	op_t        op;
	cond_t      cond;
	shift_t     shift;
	reg_num_t   reg_num;
	word_t      sximm5;
	word_t      sximm8;
	word_t      read_value;
	logic [2:0] flags;

	control_fsm fsm_i (
		.clk       (clk),
		.reset     (reset),
		.opcode    (opcode),
		.op        (op),
		.cond      (cond),
		.flags     (flags),
		.dp_ctrl   (dp_ctrl),
		.addr_ctrl (addr_ctrl),
		.load_ir   (load_ir),
		.mem_cmd   (mem_cmd),
		.halt      (halt)
	);

	program_counter #(.addr_width(addr_width)) pc_i (
		.clk          (clk),
		.addr_ctrl    (addr_ctrl),
		.offset       (sximm8),	// branch displacement
		.data_addr_in (datapath_out),
		.mem_addr     (mem_addr),
		.pc_value     ()
	);

	instr_decoder dec_i (
		.clk       (clk),
		.load_ir   (load_ir),
		.read_data (read_data),
		.reg_sel   (dp_ctrl.reg_sel),
		.opcode    (opcode),
		.op        (op),
		.cond      (cond),
		.shift     (shift),
		.reg_num   (reg_num),
		.sximm5    (sximm5),
		.sximm8    (sximm8)
	);

	register_file rf_i (
		.clk        (clk),
		.dp_ctrl    (dp_ctrl),
		.reg_num    (reg_num),
		.c_value    (datapath_out),
		.sximm8     (sximm8),
		.mem_data   (read_data),
		.read_value (read_value)
	);

	execute_unit ex_i (
		.clk        (clk),
		.dp_ctrl    (dp_ctrl),
		.read_value (read_value),
		.shift      (shift),
		.alu_op     (alu_op_t'(op)),	// op field selects the alu operation
		.sximm5     (sximm5),
		.result     (datapath_out),
		.flags      (flags)
	);

endmodule

/* logic/cpu_ctrl_pkg.sv */
// control types: sequencer states, memory command, register and write-back selects, control structs
package cpu_ctrl_pkg;

	typedef enum logic [5:0] {
		s_reset,
		s_if1,	// drive pc onto the bus
		s_if2,	// capture instruction
		s_update_pc,	// pc + 1 and dispatch
		s_mov_imm,
		s_load_a,
		s_load_b,
		s_calc,
		s_write,
		s_status,	// cmp only
		s_addr_calc,
		s_load_addr,
		s_mem_read,
		s_mem_wb,
		s_str_data,
		s_mem_write1,
		s_mem_write2,
		s_branch,
		s_halt
	} state_t;

	typedef enum logic [1:0] {
		cmd_none  = 2'b00,
		cmd_read  = 2'b01,
		cmd_write = 2'b10
	} mem_cmd_t;

	typedef enum logic [1:0] {
		sel_rn = 2'b00,
		sel_rd = 2'b01,
		sel_rm = 2'b10
	} reg_sel_t;

	typedef enum logic [1:0] {
		wb_c    = 2'b00,
		wb_imm8 = 2'b01,
		wb_mem  = 2'b10
	} wb_sel_t;

	typedef struct packed {
		reg_sel_t reg_sel;
		wb_sel_t  wb_sel;
		logic     write;	// register file write enable
		logic     load_a;
		logic     load_b;
		logic     load_c;
		logic     load_s;
		logic     a_zero;	// alu sees 0 instead of a
		logic     b_imm;	// alu sees sximm5 instead of shifted b
	} dp_ctrl_t;

	typedef struct packed {
		logic load_pc;
		logic reset_pc;
		logic take_branch;
		logic addr_pc;	// bus address from pc, else data address
		logic load_addr;
	} addr_ctrl_t;

	// bit order of the status flags
	localparam int flag_z = 2;
	localparam int flag_n = 1;
	localparam int flag_v = 0;

endpackage

/* logic/cpu_isa_pkg.sv */
// instruction set encoding: data types, field positions, opcode/op pairs and condition codes
package cpu_isa_pkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0]  reg_num_t;
	typedef logic [7:0]  imm8_t;
	typedef logic [4:0]  imm5_t;
	typedef logic [2:0]  opcode_t;
	typedef logic [1:0]  op_t;
	typedef logic [2:0]  cond_t;

	typedef enum logic [1:0] {
		sh_none = 2'b00,
		sh_lsl  = 2'b01,	// left by one
		sh_lsr  = 2'b10,	// logical right by one
		sh_asr  = 2'b11	// arithmetic right, keeps sign
	} shift_t;

	typedef enum logic [1:0] {
		alu_add  = 2'b00,
		alu_sub  = 2'b01,
		alu_and  = 2'b10,
		alu_notb = 2'b11
	} alu_op_t;

	// bit positions inside the instruction word
	localparam int opcode_msb = 15;
	localparam int opcode_lsb = 13;
	localparam int op_msb     = 12;
	localparam int op_lsb     = 11;
	localparam int rn_msb     = 10;	// also the branch condition
	localparam int rn_lsb     = 8;
	localparam int rd_msb     = 7;
	localparam int rd_lsb     = 5;
	localparam int shift_msb  = 4;
	localparam int shift_lsb  = 3;
	localparam int rm_msb     = 2;
	localparam int rm_lsb     = 0;
	localparam int imm8_msb   = 7;
	localparam int imm5_msb   = 4;

	localparam opcode_t opc_mov    = 3'b110;
	localparam opcode_t opc_alu    = 3'b101;
	localparam opcode_t opc_ldr    = 3'b011;
	localparam opcode_t opc_str    = 3'b100;
	localparam opcode_t opc_halt   = 3'b111;
	localparam opcode_t opc_branch = 3'b001;

	// {opcode, op} pairs used for dispatch
	localparam logic [4:0] instr_mov_imm = {opc_mov, 2'b10};
	localparam logic [4:0] instr_mov_reg = {opc_mov, 2'b00};
	localparam logic [4:0] instr_add     = {opc_alu, 2'b00};
	localparam logic [4:0] instr_cmp     = {opc_alu, 2'b01};
	localparam logic [4:0] instr_and     = {opc_alu, 2'b10};
	localparam logic [4:0] instr_mvn     = {opc_alu, 2'b11};
	localparam logic [4:0] instr_ldr     = {opc_ldr, 2'b00};
	localparam logic [4:0] instr_str     = {opc_str, 2'b00};
	localparam logic [4:0] instr_halt    = {opc_halt, 2'b00};
	localparam logic [4:0] instr_branch  = {opc_branch, 2'b00};

	localparam cond_t cond_al = 3'b000;
	localparam cond_t cond_eq = 3'b001;
	localparam cond_t cond_ne = 3'b010;
	localparam cond_t cond_lt = 3'b011;
	localparam cond_t cond_le = 3'b100;

endpackage

/* logic/execute_unit.sv */
// operand registers, shifter, alu, result register and status flags
`timescale 1ns/1ps

module execute_unit import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  logic       clk,
	input  dp_ctrl_t   dp_ctrl,
	input  word_t      read_value,
	input  shift_t     shift,
	input  alu_op_t    alu_op,
	input  word_t      sximm5,
	output word_t      result,
	output logic [2:0] flags
);

	word_t      a_reg;
	word_t      b_reg;
	word_t      c_reg;
	word_t      b_shifted;
	word_t      alu_a;
	word_t      alu_b;
	word_t      alu_out;
	logic [2:0] status;

	always_ff @(posedge clk) begin
		if (dp_ctrl.load_a) begin
			a_reg <= read_value;
		end
		if (dp_ctrl.load_b) begin
			b_reg <= read_value;
		end
		if (dp_ctrl.load_c) begin
			c_reg <= alu_out;
		end
		if (dp_ctrl.load_s) begin
			status[flag_z] <= (alu_out == '0);
			status[flag_n] <= alu_out[15];
			// overflow of a - b, only captured in cmp
			status[flag_v] <= (alu_a[15] ^ alu_b[15]) & (alu_out[15] ^ alu_a[15]);
		end
	end

	always_comb begin
		case (shift)
			sh_lsl:  b_shifted = {b_reg[14:0], 1'b0};
			sh_lsr:  b_shifted = {1'b0, b_reg[15:1]};
			sh_asr:  b_shifted = {b_reg[15], b_reg[15:1]};
			default: b_shifted = b_reg;
		endcase
	end

	assign alu_a = dp_ctrl.a_zero ? '0 : a_reg;
	assign alu_b = dp_ctrl.b_imm ? sximm5 : b_shifted;

	always_comb begin
		case (alu_op)
			alu_add: alu_out = alu_a + alu_b;	// wraps at 16 bits
			alu_sub: alu_out = alu_a - alu_b;
			alu_and: alu_out = alu_a & alu_b;
			default: alu_out = ~alu_b;
		endcase
	end

	assign result = c_reg;
	assign flags = status;

endmodule

/* logic/instr_decoder.sv */
// instruction register, field extraction, immediate sign extension and register number select
`timescale 1ns/1ps

module instr_decoder import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  logic     clk,
	input  logic     load_ir,
	input  word_t    read_data,
	input  reg_sel_t reg_sel,
	output opcode_t  opcode,
	output op_t      op,
	output cond_t    cond,
	output shift_t   shift,
	output reg_num_t reg_num,
	output word_t    sximm5,
	output word_t    sximm8
);

	word_t    ir;
	imm8_t    imm8;
	imm5_t    imm5;
	reg_num_t rn;
	reg_num_t rd;
	reg_num_t rm;

	always_ff @(posedge clk) begin
		if (load_ir) begin
			ir <= read_data;
		end
	end

	assign opcode = ir[opcode_msb:opcode_lsb];
	assign op = ir[op_msb:op_lsb];
	assign cond = ir[rn_msb:rn_lsb];
	assign rn = ir[rn_msb:rn_lsb];
	assign rd = ir[rd_msb:rd_lsb];
	assign rm = ir[rm_msb:rm_lsb];
	assign imm8 = ir[imm8_msb:0];
	assign imm5 = ir[imm5_msb:0];

	// ldr/str carry imm5 in the shift bits
	assign shift = (opcode == opc_ldr || opcode == opc_str) ? sh_none :
		shift_t'(ir[shift_msb:shift_lsb]);

	assign sximm8 = {{8{imm8[7]}}, imm8};
	assign sximm5 = {{11{imm5[4]}}, imm5};

	// same number for read and write
	always_comb begin
		case (reg_sel)
			sel_rd:  reg_num = rd;
			sel_rm:  reg_num = rm;
			default: reg_num = rn;
		endcase
	end

endmodule

/* logic/program_counter.sv */
// program counter, data address register and memory address select
`timescale 1ns/1ps

module program_counter import cpu_isa_pkg::*, cpu_ctrl_pkg::*; #(
	parameter int addr_width = 9
) (
	input  logic                  clk,
	input  addr_ctrl_t            addr_ctrl,
	input  word_t                 offset,
	input  word_t                 data_addr_in,
	output logic [addr_width-1:0] mem_addr,
	output logic [addr_width-1:0] pc_value
);

	logic [addr_width-1:0] next_pc;
	logic [addr_width-1:0] data_addr;

	// branch offset is relative to the already advanced pc
	always_comb begin
		if (addr_ctrl.reset_pc) begin
			next_pc = '0;
		end else if (addr_ctrl.take_branch) begin
			next_pc = pc_value + offset[addr_width-1:0];	// wraps at addr_width
		end else begin
			next_pc = pc_value + addr_width'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (addr_ctrl.load_pc) begin
			pc_value <= next_pc;
		end
		if (addr_ctrl.load_addr) begin
			data_addr <= data_addr_in[addr_width-1:0];
		end
	end

	assign mem_addr = addr_ctrl.addr_pc ? pc_value : data_addr;

endmodule

/* logic/register_file.sv */
// eight general registers with write-back source select and combinational read
`timescale 1ns/1ps

module register_file import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  logic     clk,
	input  dp_ctrl_t dp_ctrl,
	input  reg_num_t reg_num,
	input  word_t    c_value,
	input  word_t    sximm8,
	input  word_t    mem_data,
	output word_t    read_value
);

	word_t regs [0:7];
	word_t wb_value;

	always_comb begin
		case (dp_ctrl.wb_sel)
			wb_imm8: wb_value = sximm8;
			wb_mem:  wb_value = mem_data;
			default: wb_value = c_value;
		endcase
	end

	always_ff @(posedge clk) begin
		if (dp_ctrl.write) begin
			regs[reg_num] <= wb_value;
		end
	end

	assign read_value = regs[reg_num];

endmodule

/* run.sh */
#!/bin/sh
# build and run the cpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module cpu_tb -f cpu.f -o cpu_sim

out=$(./obj_dir/cpu_sim)
echo "$out"

echo "$out" | grep -q "TB PASSED"

/* tests/cpu_checker.sv */
// store and halt checker with instruction set reference model and error counters
`timescale 1ns/1ps

module cpu_checker import cpu_isa_pkg::*, cpu_ctrl_pkg::*; #(
	parameter int addr_width = 9
) (
	input  logic                  clk,
	input  logic                  reset,
	input  mem_cmd_t              mem_cmd,
	input  logic [addr_width-1:0] mem_addr,
	input  word_t                 datapath_out,
	input  logic                  halt,
	input  word_t                 image [0:511],
	output int                    mismatch_count,
	output int                    other_count,
	output int                    runs_done
);

	word_t                 ref_regs [0:7];
	word_t                 ref_mem [0:511];
	logic [addr_width-1:0] ref_pc;
	logic                  ref_z;
	logic                  ref_n;
	logic                  ref_v;

	int                    exp_cycle [$];
	logic [addr_width-1:0] exp_addr [$];
	word_t                 exp_data [$];
	int                    halt_cycle;
	int                    cyc;
	logic                  active;
	logic                  halt_seen;

	function automatic word_t shifted(word_t v, logic [1:0] sh);
		case (sh)
			2'b01:   return {v[14:0], 1'b0};
			2'b10:   return {1'b0, v[15:1]};
			2'b11:   return {v[15], v[15:1]};
			default: return v;
		endcase
	endfunction

	function automatic logic cond_holds(logic [2:0] c);
		case (c)
			3'b000:  return 1'b1;
			3'b001:  return ref_z;
			3'b010:  return ~ref_z;
			3'b011:  return ref_n ^ ref_v;
			3'b100:  return (ref_n ^ ref_v) | ref_z;
			default: return 1'b0;
		endcase
	endfunction

	// runs one instruction on the shadow state, returns its cycle count
	function automatic int step_ref(output logic st, output logic [addr_width-1:0] st_addr,
			output word_t st_data, output logic hlt);
		word_t    ins;
		word_t    b;
		word_t    r;
		word_t    sx8;
		word_t    sx5;
		word_t    ea;
		reg_num_t rn;
		reg_num_t rd;
		ins = ref_mem[ref_pc];
		ref_pc = ref_pc + addr_width'(1);
		rn = ins[10:8];
		rd = ins[7:5];
		sx8 = {{8{ins[7]}}, ins[7:0]};
		sx5 = {{11{ins[4]}}, ins[4:0]};
		b = shifted(ref_regs[ins[2:0]], ins[4:3]);
		ea = ref_regs[rn] + sx5;
		st = 1'b0;
		st_addr = '0;
		st_data = '0;
		hlt = 1'b0;
		case (ins[15:11])
			5'b11010: begin
				ref_regs[rn] = sx8;
				return 4;
			end
			5'b11000: begin
				ref_regs[rd] = b;
				return 6;
			end
			5'b10100: begin
				ref_regs[rd] = ref_regs[rn] + b;	// wraps at 16 bits
				return 7;
			end
			5'b10101: begin
				r = ref_regs[rn] - b;
				ref_z = (r == 16'h0000);
				ref_n = r[15];
				ref_v = (ref_regs[rn][15] != b[15]) && (r[15] != ref_regs[rn][15]);
				return 6;
			end
			5'b10110: begin
				ref_regs[rd] = ref_regs[rn] & b;
				return 7;
			end
			5'b10111: begin
				ref_regs[rd] = ~b;
				return 6;
			end
			5'b01100: begin
				ref_regs[rd] = ref_mem[ea[addr_width-1:0]];
				return 8;
			end
			5'b10000: begin
				st = 1'b1;
				st_addr = ea[addr_width-1:0];
				st_data = ref_regs[rd];
				ref_mem[st_addr] = st_data;
				return 9;
			end
			5'b00100: begin
				if (cond_holds(ins[10:8])) begin
					ref_pc = ref_pc + sx8[addr_width-1:0];	// relative to advanced pc
				end
				return 4;
			end
			5'b11100: begin
				hlt = 1'b1;
				return 4;
			end
			default: return 3;	// unknown encoding
		endcase
	endfunction

	task automatic build_expected();
		int                    start;
		int                    len;
		int                    n;
		logic                  st;
		logic                  hlt;
		logic [addr_width-1:0] a;
		word_t                 d;
		for (int i = 0; i < 512; i++) begin
			ref_mem[i] = image[i];
		end
		for (int i = 0; i < 8; i++) begin
			ref_regs[i] = '0;
		end
		{ref_z, ref_n, ref_v} = 3'b000;
		ref_pc = '0;
		exp_cycle.delete();
		exp_addr.delete();
		exp_data.delete();
		halt_cycle = -1;
		start = 2;	// cycle 1 is still the reset state
		hlt = 1'b0;
		n = 0;
		while (!hlt && n < 4000) begin
			len = step_ref(st, a, d, hlt);
			if (st) begin
				exp_cycle.push_back(start + 7);	// two write cycles
				exp_addr.push_back(a);
				exp_data.push_back(d);
				exp_cycle.push_back(start + 8);
				exp_addr.push_back(a);
				exp_data.push_back(d);
			end
			if (hlt) begin
				halt_cycle = start + 3;
			end
			start = start + len;
			n++;
		end
		if (halt_cycle < 0) begin
			$display("reference program never reaches HALT");
			other_count++;
		end
	endtask

	initial begin
		mismatch_count = 0;
		other_count = 0;
		runs_done = 0;
		active = 1'b0;
		halt_seen = 1'b0;
		cyc = 0;
	end

	always @(negedge clk) begin
		if (reset) begin
			cyc = 0;
			active = 1'b0;
		end else begin
			if (!active) begin
				build_expected();
				active = 1'b1;
				halt_seen = 1'b0;
			end
			cyc++;
			if (mem_cmd == cmd_write) begin
				if (exp_cycle.size() == 0) begin
					$display("unexpected write at %0t to address %0d", $time, mem_addr);
					other_count++;
				end else begin
					if (exp_cycle[0] != cyc || exp_addr[0] != mem_addr ||
							exp_data[0] != datapath_out) begin
						$display("Mismatch at %0t: store %0d=%h cycle %0d, expected %0d=%h cycle %0d",
							$time, mem_addr, datapath_out, cyc, exp_addr[0], exp_data[0],
							exp_cycle[0]);
						mismatch_count++;
					end
					void'(exp_cycle.pop_front());
					void'(exp_addr.pop_front());
					void'(exp_data.pop_front());
				end
			end
			if (halt && !halt_seen) begin
				halt_seen = 1'b1;
				if (cyc != halt_cycle) begin
					$display("halt rose in cycle %0d instead of cycle %0d", cyc, halt_cycle);
					other_count++;
				end
				if (exp_cycle.size() != 0) begin
					$display("%0d expected store cycles never happened", exp_cycle.size());
					other_count++;
				end
				runs_done++;
			end
			if (halt_seen && !halt) begin
				$display("halt fell at %0t without a reset", $time);
				other_count++;
			end
			if (halt_seen && mem_cmd != cmd_none) begin
				$display("memory command at %0t after halt", $time);
				other_count++;
			end
		end
	end

endmodule

/* tests/cpu_tb.sv */
// testbench top: clock, reset, memory model, random program build and watchdog
`timescale 1ns/1ps

module cpu_tb import cpu_isa_pkg::*, cpu_ctrl_pkg::*;;

	logic     clk;
	logic     reset;
	word_t    read_data;
	mem_cmd_t mem_cmd;
	logic [8:0] mem_addr;
	word_t    datapath_out;
	logic     halt;

	word_t mem [0:511];
	word_t image [0:511];
	word_t prog [$];
	int    slot;
	int    prog_len;
	int    tb_errors;
	int    mismatch_count;
	int    other_count;
	int    runs_done;
	real   limit_ns;

	cpu #(.addr_width(9)) cpu_i (
		.clk          (clk),
		.reset        (reset),
		.read_data    (read_data),
		.mem_cmd      (mem_cmd),
		.mem_addr     (mem_addr),
		.datapath_out (datapath_out),
		.halt         (halt)
	);

	cpu_checker #(.addr_width(9)) chk_i (
		.clk            (clk),
		.reset          (reset),
		.mem_cmd        (mem_cmd),
		.mem_addr       (mem_addr),
		.datapath_out   (datapath_out),
		.halt           (halt),
		.image          (image),
		.mismatch_count (mismatch_count),
		.other_count    (other_count),
		.runs_done      (runs_done)
	);

	assign read_data = mem[mem_addr];	// combinational read

	always @(posedge clk) begin
		if (mem_cmd == cmd_write) begin
			mem[mem_addr] <= datapath_out;
		end
	end

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic word_t enc_mov_imm(reg_num_t rn, imm8_t imm);
		return {opc_mov, 2'b10, rn, imm};
	endfunction

	function automatic word_t enc_reg(opcode_t opc, op_t op, reg_num_t rn, reg_num_t rd,
			shift_t sh, reg_num_t rm);
		return {opc, op, rn, rd, sh, rm};
	endfunction

	function automatic word_t enc_mem(opcode_t opc, reg_num_t rn, reg_num_t rd, imm5_t imm);
		return {opc, 2'b00, rn, rd, imm};
	endfunction

	function automatic word_t enc_branch(cond_t c, imm8_t off);
		return {opc_branch, 2'b00, c, off};
	endfunction

	function automatic reg_num_t rand_reg();
		return reg_num_t'($urandom_range(4, 0));	// r5..r7 are pointers
	endfunction

	// store rd at the result pointer r7, bump r7 by r6 every 16 words
	task automatic store_result(reg_num_t rd);
		prog.push_back(enc_mem(opc_str, 3'd7, rd, imm5_t'(slot)));
		slot++;
		if (slot == 16) begin
			prog.push_back(enc_reg(opc_alu, 2'b00, 3'd7, 3'd7, sh_none, 3'd6));
			slot = 0;
		end
	endtask

	task automatic branch_case(cond_t c, imm8_t a, imm8_t b);
		prog.push_back(enc_mov_imm(3'd0, a));
		prog.push_back(enc_mov_imm(3'd1, b));
		prog.push_back(enc_reg(opc_alu, 2'b01, 3'd0, 3'd0, sh_none, 3'd1));
		prog.push_back(enc_branch(c, 8'd2));
		prog.push_back(enc_mov_imm(3'd2, 8'd11));	// marker when not taken
		prog.push_back(enc_branch(cond_al, 8'd1));
		prog.push_back(enc_mov_imm(3'd2, 8'd22));	// marker when taken
		store_result(3'd2);
	endtask

	task automatic build_program();
		cond_t    conds [5];
		imm8_t    v;
		imm8_t    lo;
		imm8_t    hi;
		reg_num_t rd;
		conds = '{cond_al, cond_eq, cond_ne, cond_lt, cond_le};
		slot = 0;
		for (int r = 0; r < 5; r++) begin
			prog.push_back(enc_mov_imm(reg_num_t'(r), imm8_t'($urandom())));
		end
		prog.push_back(enc_mov_imm(3'd5, 8'd100));
		prog.push_back(enc_mov_imm(3'd6, 8'd16));
		prog.push_back(enc_mov_imm(3'd7, 8'd75));
		for (int i = 0; i < 2; i++) begin
			prog.push_back(enc_reg(opc_mov, 2'b00, 3'd0, 3'd5, sh_lsl, 3'd5));	// ends at 400
			prog.push_back(enc_reg(opc_mov, 2'b00, 3'd0, 3'd7, sh_lsl, 3'd7));	// ends at 300
		end
		for (int r = 0; r < 5; r++) begin
			store_result(reg_num_t'(r));
		end
		for (int s = 0; s < 4; s++) begin
			rd = rand_reg();
			prog.push_back(enc_reg(opc_mov, 2'b00, 3'd0, rd, shift_t'(s), rand_reg()));
			store_result(rd);
			rd = rand_reg();
			prog.push_back(enc_reg(opc_alu, 2'b11, 3'd0, rd, shift_t'(s), rand_reg()));
			store_result(rd);
		end
		for (int i = 0; i < 8; i++) begin
			rd = rand_reg();
			prog.push_back(enc_reg(opc_alu, (i % 2 == 0) ? 2'b00 : 2'b10, rand_reg(), rd,
				shift_t'($urandom_range(3, 0)), rand_reg()));
			store_result(rd);
		end
		prog.push_back(enc_mov_imm(3'd3, 8'h80));	// 0xff80 + 0xff80 carries out
		prog.push_back(enc_reg(opc_alu, 2'b00, 3'd3, 3'd4, sh_none, 3'd3));
		store_result(3'd4);
		for (int c = 0; c < 5; c++) begin
			v = imm8_t'($urandom());
			lo = {1'b1, 7'($urandom())};
			hi = {1'b0, 7'($urandom())};
			branch_case(conds[c], v, v);
			branch_case(conds[c], lo, hi);
			branch_case(conds[c], hi, lo);
		end
		for (int i = 0; i < 4; i++) begin
			rd = rand_reg();
			prog.push_back(enc_mem(opc_ldr, 3'd5, rd, imm5_t'($urandom_range(15, 0))));
			store_result(rd);
		end
		prog.push_back({opc_halt, 2'b00, 11'd0});
	endtask

	task automatic wait_runs(int n);
		while (runs_done < n) begin
			@(posedge clk);
		end
	endtask

	initial begin
		reset = 1'b1;
		tb_errors = 0;
		prog_len = 0;
		void'($urandom(47));
		for (int i = 0; i < 512; i++) begin
			image[i] = {7'b1110000, 9'(i)};	// stray fetch reads a halt
		end
		for (int i = 400; i < 416; i++) begin
			image[i] = word_t'($urandom());
		end
		build_program();
		foreach (prog[i]) begin
			image[i] = prog[i];
		end
		for (int i = 0; i < 512; i++) begin
			mem[i] = image[i];
		end
		prog_len = prog.size();
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
		wait_runs(1);
		repeat (20) @(posedge clk);	// halted, checker watches for commands
		#1 reset = 1'b1;
		@(posedge clk);
		#1 reset = 1'b0;
		@(negedge clk);
		if (halt) begin
			$display("halt stayed high after the reset pulse");
			tb_errors++;
		end
		wait_runs(2);
		repeat (20) @(posedge clk);
		$display("errors: store mismatches %0d, other %0d", mismatch_count,
			other_count + tb_errors);
		if (mismatch_count == 0 && other_count == 0 && tb_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// two runs of the program plus idle and reset time
	initial begin
		wait (prog_len > 0);
		limit_ns = (2.0 * prog_len * 9.0 + 60.0) * 4.0 + 200.0;
		#(limit_ns);
		$display("timeout after %0t, program did not reach halt", $time);
		$display("TB FAILED");
		$finish;
	end

endmodule
